// ==== Bender.yml ====
package:
  name: heart_monitor

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/signalPkg.sv
      - rtl/controlPkg.sv
      - rtl/spiSampleReceiver.sv
      - rtl/firFilter.sv
      - rtl/peakDetector.sv
      - rtl/heartRateMeter.sv
      - rtl/dacSerializer.sv
      - rtl/heartMonitorTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/heartMonitor_properties.sv
      - verif/heartMonitorTb.sv

// ==== project.f ====
+incdir+rtl
rtl/signalPkg.sv
rtl/controlPkg.sv
rtl/spiSampleReceiver.sv
rtl/firFilter.sv
rtl/peakDetector.sv
rtl/heartRateMeter.sv
rtl/dacSerializer.sv
rtl/heartMonitorTop.sv
verif/heartMonitor_properties.sv
verif/heartMonitorTb.sv

// ==== rtl/controlPkg.sv ====
/* state encodings for the peak detector and DAC sequencer */
package controlPkg;

	// peak detector, hold keeps the LED lit
	typedef enum logic {
		SEARCH,
		HOLD
	} peakState_e;

	// DAC sequencing within one frame
	typedef enum logic [1:0] {
		IDLE,
		SHIFT, // 11 data bits out
		STROBE, // load pulled low
		RECOVER // load back high
	} dacState_e;

endpackage

// ==== rtl/dacSerializer.sv ====
/* DAC command word build, serial shift-out and active-low load strobe */
`include "heartMonitor_defines.svh"

module dacSerializer
	import signalPkg::*, controlPkg::*;
(
	input logic sck,
	input logic reset,
	input sample_t filtered,
	input logic filtValid,
	output logic dacSerial,
	output logic dacLoad
);
	localparam int BIT_W = $clog2(`DAC_W);

	dacState_e state;
	logic [`DAC_W-1:0] dacWord; // shifts out MSB first
	logic [BIT_W-1:0] bitCnt;

	always_ff @(posedge sck, posedge reset)
		if (reset)
		begin
			state <= IDLE;
			bitCnt <= '0;
			dacSerial <= 1'b0;
			dacLoad <= 1'b1;
		end
		else
			case (state)
				IDLE:
					if (filtValid)
					begin
						state <= SHIFT;
						bitCnt <= '0;
					end
				SHIFT:
				begin
					dacSerial <= dacWord[`DAC_W-1];
					bitCnt <= bitCnt + 1'b1;
					if (bitCnt == BIT_W'(`DAC_W - 1))
						state <= STROBE; // last bit is out
				end
				STROBE:
				begin
					dacLoad <= 1'b0; // DAC latches the word
					state <= RECOVER;
				end
				RECOVER:
				begin
					dacLoad <= 1'b1;
					state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase

	// channel A, 1x range, top 8 bits of the sample
	always_ff @(posedge sck)
		if (state == IDLE && filtValid)
			dacWord <= {2'b00, 1'b0, filtered[`SAMPLE_W-1:2]};
		else if (state == SHIFT)
			dacWord <= {dacWord[`DAC_W-2:0], 1'b0};

endmodule

// ==== rtl/firFilter.sv ====
/* 31-tap symmetric FIR low-pass with folded tap pairs
   and saturation of the scaled result */
`include "heartMonitor_defines.svh"

module firFilter
	import signalPkg::*;
(
	input logic sck,
	input logic reset,
	input sample_t sample,
	input logic sampleValid,
	output sample_t filtered,
	output logic filtValid
);
	localparam int CENTER = `FIR_TAPS / 2; // tap 15
	localparam int ACC_W = `SAMPLE_W + `COEF_W + 3; // 1023 * 1028 fits

	sample_t delayLine [`FIR_TAPS-1]; // x[n-1] .. x[n-30]
	sample_t taps [`FIR_TAPS]; // window including the new sample
	logic [ACC_W-1:0] acc;
	logic [ACC_W-1:0] scaled;

	// new sample enters at tap 0 in the same cycle
	always_comb
	begin
		taps[0] = sample;
		for (int k = 1; k < `FIR_TAPS; k++)
			taps[k] = delayLine[k-1];
	end

	// fold mirrored taps before the multiply
	always_comb
	begin
		acc = ACC_W'(taps[CENTER]) * ACC_W'(coefTable[CENTER]);
		for (int k = 0; k < CENTER; k++)
			acc = acc + (ACC_W'(taps[k]) + ACC_W'(taps[`FIR_TAPS-1-k]))
				* ACC_W'(coefTable[k]);
	end

	assign scaled = acc >> `COEF_SHIFT;

	always_ff @(posedge sck, posedge reset)
		if (reset)
		begin
			for (int k = 0; k < `FIR_TAPS - 1; k++)
				delayLine[k] <= '0;
			filtValid <= 1'b0;
		end
		else
		begin
			filtValid <= sampleValid; // one cycle behind the sample
			if (sampleValid)
			begin
				delayLine[0] <= sample;
				for (int k = 1; k < `FIR_TAPS - 1; k++)
					delayLine[k] <= delayLine[k-1];
			end
		end

	// gain slightly above one, so clip at full scale
	always_ff @(posedge sck)
		if (sampleValid)
		begin
			if (|scaled[ACC_W-1:`SAMPLE_W])
				filtered <= '1;
			else
				filtered <= scaled[`SAMPLE_W-1:0];
		end

endmodule

// ==== rtl/heartMonitorTop.sv ====
/* heart rate monitor signal chain: receiver, FIR,
   then peak detector, rate meter and DAC serializer */
module heartMonitorTop
	import signalPkg::*;
(
	input logic sck,
	input logic reset,
	input logic sdo, // ADC serial data
	output logic peakLed,
	output peakCount_t peakCount,
	output rate_t heartRate,
	output logic rateValid,
	output logic dacSerial,
	output logic dacLoad // active low
);
	sample_t sample;
	logic sampleValid; // frame reference for the chain
	sample_t filtered;
	logic filtValid;
	logic peakPulse;

	spiSampleReceiver spiSampleReceiver_i (
		.sck(sck),
		.reset(reset),
		.sdo(sdo),
		.sample(sample),
		.sampleValid(sampleValid)
	);

	firFilter firFilter_i (
		.sck(sck),
		.reset(reset),
		.sample(sample),
		.sampleValid(sampleValid),
		.filtered(filtered),
		.filtValid(filtValid)
	);

	// three consumers of the filtered stream
	peakDetector peakDetector_i (
		.sck(sck),
		.reset(reset),
		.filtered(filtered),
		.filtValid(filtValid),
		.peakLed(peakLed),
		.peakPulse(peakPulse),
		.peakCount(peakCount)
	);

	heartRateMeter heartRateMeter_i (
		.sck(sck),
		.reset(reset),
		.filtValid(filtValid),
		.peakPulse(peakPulse),
		.heartRate(heartRate),
		.rateValid(rateValid)
	);

	dacSerializer dacSerializer_i (
		.sck(sck),
		.reset(reset),
		.filtered(filtered),
		.filtValid(filtValid),
		.dacSerial(dacSerial),
		.dacLoad(dacLoad)
	);

endmodule

// ==== rtl/heartMonitor_defines.svh ====
/* widths, frame timing, filter and peak detector constants
   for the heart rate monitor signal path */
`ifndef HEART_MONITOR_DEFINES_SVH
`define HEART_MONITOR_DEFINES_SVH

// serial framing
`define SAMPLE_W 10 // ADC sample bits
`define FRAME_W 16 // bits per SPI word
`define FRAME_LEN 16 // sck cycles per frame

// FIR low-pass
`define FIR_TAPS 31
`define COEF_W 8
`define COEF_SHIFT 10 // coefficients scaled by 1024

// slope window peak detector
`define WINDOW_LEN 128 // slope bits kept
`define HALF_LEN 64
`define LEFT_MAX 55 // older half must hold no more ones than this
`define RIGHT_MIN 40 // newer half needs at least this many ones
`define HOLD_LEN 128 // samples the LED stays lit

// heart rate
`define RATE_SAMPLES 256 // samples per rate window
`define BPM_MULT 6
`define RATE_W 12

// DAC command word
`define DAC_W 11

`endif

// ==== rtl/heartRateMeter.sv ====
/* peaks per fixed sample window, latched as beats per minute */
`include "heartMonitor_defines.svh"

module heartRateMeter
	import signalPkg::*;
(
	input logic sck,
	input logic reset,
	input logic filtValid,
	input logic peakPulse,
	output rate_t heartRate,
	output logic rateValid
);
	localparam int CNT_W = $clog2(`RATE_SAMPLES);

	logic sampleTick; // filtValid delayed, lines up with peakPulse
	logic [CNT_W-1:0] sampleCnt;
	peakCount_t winPeaks;

	always_ff @(posedge sck, posedge reset)
		if (reset)
		begin
			sampleTick <= 1'b0;
			sampleCnt <= '0;
			winPeaks <= '0;
			heartRate <= '0;
			rateValid <= 1'b0;
		end
		else
		begin
			sampleTick <= filtValid;
			rateValid <= 1'b0;
			if (sampleTick)
			begin
				if (sampleCnt == CNT_W'(`RATE_SAMPLES - 1))
				begin
					// last sample, its own peak still belongs here
					heartRate <= rate_t'(winPeaks + peakCount_t'(peakPulse))
						* rate_t'(`BPM_MULT);
					rateValid <= 1'b1;
					sampleCnt <= '0;
					winPeaks <= '0; // window restarts
				end
				else
				begin
					sampleCnt <= sampleCnt + 1'b1;
					winPeaks <= winPeaks + peakCount_t'(peakPulse);
				end
			end
		end

endmodule

// ==== rtl/peakDetector.sv ====
/* slope window peak detector with running half sums,
   LED hold timer and peak counter */
`include "heartMonitor_defines.svh"

module peakDetector
	import signalPkg::*, controlPkg::*;
(
	input logic sck,
	input logic reset,
	input sample_t filtered,
	input logic filtValid,
	output logic peakLed,
	output logic peakPulse,
	output peakCount_t peakCount
);
	localparam int SUM_W = $clog2(`HALF_LEN + 1); // holds 0..64
	localparam int HOLD_W = $clog2(`HOLD_LEN);

	peakState_e state;
	sample_t prevSample;
	logic slopeBit;
	logic [`WINDOW_LEN-1:0] window; // bit 0 newest
	logic [SUM_W-1:0] leftSum; // ones in older half
	logic [SUM_W-1:0] rightSum; // ones in newer half
	logic [SUM_W-1:0] leftNext;
	logic [SUM_W-1:0] rightNext;
	logic [HOLD_W-1:0] holdCnt;
	logic found;

	assign slopeBit = (filtered <= prevSample); // not rising

	// bit at HALF_LEN-1 crosses into the older half, top bit drops out
	assign rightNext = rightSum + SUM_W'(slopeBit) - SUM_W'(window[`HALF_LEN-1]);
	assign leftNext = leftSum + SUM_W'(window[`HALF_LEN-1]) - SUM_W'(window[`WINDOW_LEN-1]);

	// rising then falling shape, judged on the updated sums
	assign found = (state == SEARCH) && (leftNext <= `LEFT_MAX) && (rightNext >= `RIGHT_MIN);

	always_ff @(posedge sck, posedge reset)
		if (reset)
		begin
			state <= SEARCH;
			prevSample <= '0;
			window <= '1; // starts as all falling
			leftSum <= SUM_W'(`HALF_LEN);
			rightSum <= SUM_W'(`HALF_LEN);
			holdCnt <= '0;
			peakLed <= 1'b0;
			peakPulse <= 1'b0;
			peakCount <= '0;
		end
		else
		begin
			peakPulse <= 1'b0;
			if (filtValid)
			begin
				prevSample <= filtered;
				window <= {window[`WINDOW_LEN-2:0], slopeBit};
				leftSum <= leftNext;
				rightSum <= rightNext;
				case (state)
					SEARCH:
						if (found)
						begin
							state <= HOLD;
							holdCnt <= '0;
							peakLed <= 1'b1;
							peakPulse <= 1'b1; // to rate meter
							peakCount <= peakCount + 1'b1;
						end
					HOLD:
						if (holdCnt == HOLD_W'(`HOLD_LEN - 1))
						begin
							state <= SEARCH; // 128 samples done
							peakLed <= 1'b0;
						end
						else
							holdCnt <= holdCnt + 1'b1;
					default:
						state <= SEARCH;
				endcase
			end
		end

endmodule

// ==== rtl/signalPkg.sv ====
/* sample, coefficient, peak count and rate types,
   plus the half table of FIR coefficients */
`include "heartMonitor_defines.svh"

package signalPkg;

	typedef logic [`SAMPLE_W-1:0] sample_t; // raw or filtered
	typedef logic [`COEF_W-1:0] coef_t;
	typedef logic [7:0] peakCount_t; // wraps at 256
	typedef logic [`RATE_W-1:0] rate_t; // beats per minute

	// taps 0..15, filter mirrors them around tap 15
	// sum of all 31 taps is 1028, close to unity gain after >>10
	localparam coef_t coefTable [16] = '{
		8'd3, 8'd4, 8'd6, 8'd8,
		8'd12, 8'd17, 8'd23, 8'd29,
		8'd36, 8'd43, 8'd50, 8'd56,
		8'd61, 8'd65, 8'd67, 8'd68
	};

endpackage

// ==== rtl/spiSampleReceiver.sv ====
/* frame counter and serial-to-parallel capture of ADC samples */
`include "heartMonitor_defines.svh"

module spiSampleReceiver
	import signalPkg::*;
(
	input logic sck,
	input logic reset,
	input logic sdo,
	output sample_t sample,
	output logic sampleValid
);
	localparam int POS_W = $clog2(`FRAME_LEN);

	logic [POS_W-1:0] framePos; // bit position in frame
	logic [`FRAME_W-2:0] shiftReg; // bits received so far
	logic [`FRAME_W-1:0] frameWord;

	assign frameWord = {shiftReg, sdo}; // complete on the last bit

	always_ff @(posedge sck, posedge reset)
		if (reset)
		begin
			framePos <= '0;
			sampleValid <= 1'b0;
		end
		else
		begin
			framePos <= framePos + 1'b1; // wraps every frame
			sampleValid <= (framePos == POS_W'(`FRAME_LEN - 1));
		end

	// MSB first, upper bits of the word are dropped
	always_ff @(posedge sck)
	begin
		shiftReg <= frameWord[`FRAME_W-2:0];
		if (framePos == POS_W'(`FRAME_LEN - 1))
			sample <= frameWord[`SAMPLE_W-1:0];
	end

endmodule

// ==== verif/heartMonitorTb.sv ====
/* testbench for the heart monitor chain: LFSR pulse stimulus,
   reference model of receiver, FIR, peak detector, rate meter and DAC word */
`include "heartMonitor_defines.svh"

module heartMonitorTb
	import signalPkg::*;
();
	localparam int NUM_SAMPLES = 1100; // a bit over four rate windows

	logic sck;
	logic reset;
	logic sdo;
	logic peakLed;
	peakCount_t peakCount;
	rate_t heartRate;
	logic rateValid;
	logic dacSerial;
	logic dacLoad;

	logic [15:0] lfsr; // Galois, taps 16 14 13 11
	logic [`FRAME_W-1:0] word;
	int level; // pulse generator state
	int segLeft;
	int step;
	logic rising;
	int firLine [`FIR_TAPS]; // model delay line, index 0 newest
	int prevY;
	logic [`WINDOW_LEN-1:0] slopeWin;
	logic holding;
	int holdLeft;
	logic expLed;
	int expCount;
	int winSamples;
	int winPeaks;
	logic rateDue; // last sample closed a rate window
	int expRate;
	logic [`DAC_W-1:0] expWord;
	int peaksTotal;
	int ratesSeen; // rateValid pulses seen on the DUT
	int errs [6]; // reset, DAC word, strobe, peak, rate, assertions

	always #50 sck = ~sck;

	heartMonitorTop heartMonitorTop_i (
		.sck(sck),
		.reset(reset),
		.sdo(sdo),
		.peakLed(peakLed),
		.peakCount(peakCount),
		.heartRate(heartRate),
		.rateValid(rateValid),
		.dacSerial(dacSerial),
		.dacLoad(dacLoad)
	);

	// one step per bit, the bit taken is the one shifted out
	function automatic int takeBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	// short steep rise, long slow fall, a little noise on top
	function automatic int nextSample();
		int s;
		if (segLeft == 0)
		begin
			rising = !rising;
			if (rising)
			begin
				segLeft = 24 + takeBits(5);
				step = 12 + takeBits(3);
			end
			else
			begin
				segLeft = 56 + takeBits(5);
				step = 4 + takeBits(3);
			end
		end
		segLeft--;
		level = rising ? level + step : level - step;
		if (level > 1023)
			level = 1023; // plateau drives the filter into saturation
		if (level < 40)
			level = 40;
		s = level + takeBits(2);
		return (s > 1023) ? 1023 : s;
	endfunction

	function automatic void modelSample(input int x);
		int acc;
		int y;
		int left;
		int right;
		logic pulse;
		acc = 0;
		left = 0;
		right = 0;
		pulse = 1'b0;
		for (int k = `FIR_TAPS - 1; k > 0; k--)
			firLine[k] = firLine[k-1];
		firLine[0] = x;
		// taps mirror around the center one
		for (int k = 0; k < `FIR_TAPS; k++)
			acc += firLine[k] * int'(coefTable[(k <= `FIR_TAPS / 2) ? k : `FIR_TAPS - 1 - k]);
		y = acc >> `COEF_SHIFT;
		if (y > 1023)
			y = 1023;
		slopeWin = {slopeWin[`WINDOW_LEN-2:0], (y <= prevY)}; // 1 when not rising
		prevY = y;
		for (int k = 0; k < `HALF_LEN; k++)
		begin
			right += int'(slopeWin[k]);
			left += int'(slopeWin[k + `HALF_LEN]);
		end
		if (!holding)
		begin
			if (left <= `LEFT_MAX && right >= `RIGHT_MIN)
			begin
				holding = 1'b1;
				holdLeft = `HOLD_LEN;
				expLed = 1'b1;
				expCount = (expCount + 1) % 256;
				pulse = 1'b1;
				peaksTotal++;
			end
		end
		else
		begin
			holdLeft--;
			if (holdLeft == 0)
			begin
				holding = 1'b0; // LED off after 128 samples
				expLed = 1'b0;
			end
		end
		winPeaks += int'(pulse); // a peak on the last sample still counts
		winSamples++;
		rateDue = (winSamples == `RATE_SAMPLES);
		if (rateDue)
		begin
			expRate = winPeaks * `BPM_MULT;
			winPeaks = 0;
			winSamples = 0;
		end
		expWord = {3'b000, 8'(y >> 2)}; // channel 00, range 0, top 8 bits
	endfunction

	function automatic void reportMismatch(input int idx, input string msg);
		errs[idx]++;
		$display("MISMATCH at time %0t: %s", $time, msg);
	endfunction

	function automatic void checkResetValues(input string where);
		if (peakLed !== 1'b0 || peakCount !== '0 || heartRate !== '0 || rateValid !== 1'b0
			|| dacSerial !== 1'b0 || dacLoad !== 1'b1)
			reportMismatch(0, $sformatf("outputs not at reset values %s", where));
	endfunction

	// state after edge p of frame f
	function automatic void checkOutputs(input int f, input int p);
		if (f == 0)
			checkResetValues($sformatf("in frame 0 at position %0d", p));
		else
		begin
			if (dacLoad !== (p != 13))
				reportMismatch(2, $sformatf("frame %0d pos %0d dacLoad %b", f, p, dacLoad));
			if (p >= 2 && p <= 12 && dacSerial !== expWord[12 - p])
				reportMismatch(1, $sformatf("frame %0d bit %0d dacSerial %b, expected %b",
					f, 12 - p, dacSerial, expWord[12 - p]));
			if (p == 1 && (peakLed !== expLed || peakCount !== peakCount_t'(expCount)))
				reportMismatch(3, $sformatf("frame %0d peakLed %b count %0d, expected %b %0d",
					f, peakLed, peakCount, expLed, expCount));
			if (rateValid !== (p == 2 && rateDue))
				reportMismatch(4, $sformatf("frame %0d pos %0d rateValid %b", f, p, rateValid));
			if (rateValid === 1'b1)
				ratesSeen++;
			if (p == 2 && rateDue && heartRate !== rate_t'(expRate))
				reportMismatch(4, $sformatf("frame %0d heartRate %0d, expected %0d",
					f, heartRate, expRate));
		end
	endfunction

	function automatic void printResult(input string name, input int n);
		$display("test %s: %s, %0d errors", name, (n == 0) ? "PASS" : "FAIL", n);
	endfunction

	initial
	begin
		int curSample;
		int total;
		int failedTests;
		sck = 1'b0;
		reset = 1'b1;
		sdo = 1'b0;
		lfsr = 16'd89;
		level = 80;
		segLeft = 0;
		step = 0;
		rising = 1'b0; // first segment rises
		for (int k = 0; k < `FIR_TAPS; k++)
			firLine[k] = 0;
		prevY = 0;
		slopeWin = '1;
		holding = 1'b0;
		holdLeft = 0;
		expLed = 1'b0;
		expCount = 0;
		winSamples = 0;
		winPeaks = 0;
		rateDue = 1'b0;
		expRate = 0;
		expWord = '0;
		peaksTotal = 0;
		ratesSeen = 0;
		curSample = 0;
		for (int t = 0; t < 6; t++)
			errs[t] = 0;

		for (int c = 0; c < 3; c++)
		begin
			@(negedge sck);
			checkResetValues("during reset");
		end
		reset = 1'b0; // next rising edge is p=0

		// frame f carries sample f, outputs for sample f-1 appear in it
		for (int f = 0; f <= NUM_SAMPLES; f++)
		begin
			if (f > 0)
				modelSample(curSample);
			curSample = nextSample();
			word = {6'(takeBits(6)), 10'(curSample)}; // random upper bits
			for (int p = 0; p < `FRAME_LEN; p++)
			begin
				sdo = word[`FRAME_W-1-p]; // MSB first
				@(negedge sck);
				checkOutputs(f, p);
			end
			if (f == 0)
				printResult("reset state", errs[0]);
		end

		if (peaksTotal == 0)
		begin
			errs[3]++;
			$display("stimulus produced no peaks, detector was not exercised");
		end
		if (ratesSeen < 4)
		begin
			errs[4]++;
			$display("heart rate reported for only %0d windows, at least four expected", ratesSeen);
		end
		errs[5] = heartMonitorTop_i.heartMonitorProperties_i.assertFails;
		printResult("DAC word", errs[1]);
		printResult("load strobe", errs[2]);
		printResult("peak detection", errs[3]);
		printResult("heart rate", errs[4]);
		printResult("assertions", errs[5]);

		total = 0;
		failedTests = 0;
		for (int t = 0; t < 6; t++)
		begin
			total += errs[t];
			if (errs[t] != 0)
				failedTests++;
		end
		$display("tests 6, failed %0d, errors %0d, peaks %0d, rate windows %0d",
			failedTests, total, peaksTotal, ratesSeen);
		if (total == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== verif/heartMonitor_properties.sv ====
/* concurrent checks on the rate strobe, DAC load pulse and peak counter */
module heartMonitorProperties
	import signalPkg::*;
(
	input logic sck,
	input logic reset,
	input logic rateValid,
	input logic dacLoad,
	input logic peakLed,
	input peakCount_t peakCount
);
	int assertFails = 0; // collected by the testbench at the end

	rateOnePulse: assert property (@(posedge sck) disable iff (reset)
		rateValid |=> !rateValid)
		else
		begin
			assertFails++;
			$error("rateValid high for more than one cycle");
		end

	// load strobe is a single low cycle
	loadShortLow: assert property (@(posedge sck) disable iff (reset)
		!dacLoad |=> dacLoad)
		else
		begin
			assertFails++;
			$error("dacLoad low for two cycles in a row");
		end

	countOnRise: assert property (@(posedge sck) disable iff (reset)
		(peakCount != $past(peakCount)) |-> (peakLed && !$past(peakLed)))
		else
		begin
			assertFails++;
			$error("peakCount changed without a rising peakLed");
		end

endmodule

bind heartMonitorTop heartMonitorProperties heartMonitorProperties_i (
	.sck(sck),
	.reset(reset),
	.rateValid(rateValid),
	.dacLoad(dacLoad),
	.peakLed(peakLed),
	.peakCount(peakCount)
);
